// ==== build.f ====
rtl/doppler_pkg.sv
rtl/doppler_settings.sv
rtl/ppx_timer.sv
rtl/zc_detector.sv
rtl/crossing_rate_counter.sv
rtl/doppler_tracker_top.sv
verification/tb_doppler_tracker.sv

// ==== rtl/crossing_rate_counter.sv ====
`timescale 1ns/10ps

module crossing_rate_counter
  import doppler_pkg::*;
(
  input  logic               ce_clk,
  input  logic               ce_rst,
  input  logic               i_crossing_i,
  input  logic               i_crossing_q,
  input  logic               i_ppx,
  output logic [COUNT_W-1:0] o_count_i,
  output logic [COUNT_W-1:0] o_count_q,
  output logic [COUNT_W-1:0] o_rate,
  output logic               o_rate_valid
);

  logic [COUNT_W-1:0] run_i_r;
  logic [COUNT_W-1:0] run_q_r;
  logic [COUNT_W-1:0] latch_i_r;
  logic [COUNT_W-1:0] latch_q_r;
  logic [COUNT_W-1:0] rate_r;
  logic               rate_valid_r;
  logic [COUNT_W:0]   sum;

  // carry kept, then halved
  assign sum = {1'b0, run_i_r} + {1'b0, run_q_r};

  // ----------------------------------------------------------
  // window counters
  // ----------------------------------------------------------
  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      run_i_r      <= '0;
      run_q_r      <= '0;
      latch_i_r    <= '0;
      latch_q_r    <= '0;
      rate_r       <= '0;
      rate_valid_r <= 1'b0;
    end else begin
      rate_valid_r <= i_ppx;
      if (i_ppx) begin
        // close the window
        latch_i_r <= run_i_r;
        latch_q_r <= run_q_r;
        rate_r    <= sum[COUNT_W:1];
        // a crossing on this edge opens the next one
        run_i_r   <= COUNT_W'(i_crossing_i);
        run_q_r   <= COUNT_W'(i_crossing_q);
      end else begin
        run_i_r <= run_i_r + COUNT_W'(i_crossing_i);
        run_q_r <= run_q_r + COUNT_W'(i_crossing_q);
      end
    end
  end

  assign o_count_i    = latch_i_r;
  assign o_count_q    = latch_q_r;
  assign o_rate       = rate_r;
  assign o_rate_valid = rate_valid_r;

endmodule

// ==== rtl/doppler_pkg.sv ====
package doppler_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------
  localparam int SAMPLE_W   = 16;
  localparam int COUNT_W    = 32;
  localparam int SET_ADDR_W = 8;
  localparam int SET_DATA_W = 32;
  localparam int RB_DATA_W  = 64;

  // ----------------------------------------------------------
  // settings and readback addresses
  // ----------------------------------------------------------
  localparam logic [SET_ADDR_W-1:0] SR_THRESHOLD = 8'd194;
  localparam logic [SET_ADDR_W-1:0] SR_OFFSET    = 8'd195;
  localparam logic [SET_ADDR_W-1:0] SR_PPX_RATE  = 8'd200;

  localparam logic [SET_ADDR_W-1:0] RB_SETTINGS = 8'd0;
  localparam logic [SET_ADDR_W-1:0] RB_COUNTS   = 8'd1;
  localparam logic [SET_ADDR_W-1:0] RB_RATE     = 8'd2;

  // returned for any address not decoded
  localparam logic [RB_DATA_W-1:0] RB_BAD = 64'h0BADC0DE_0BADC0DE;

  // shortest interval the timer will run
  localparam logic [COUNT_W-1:0] PPX_RATE_MIN = 32'd2;

  // ----------------------------------------------------------
  // types
  // ----------------------------------------------------------

  // i in the upper half, q in the lower
  typedef struct packed {
    logic signed [SAMPLE_W-1:0] i;
    logic signed [SAMPLE_W-1:0] q;
  } iq_pair_t;

  // settings word, plain for the rate, split for threshold/offset
  typedef union packed {
    logic [SET_DATA_W-1:0] word;
    iq_pair_t              pair;
  } set_word_u;

  // hysteresis state of one rail
  typedef enum logic [1:0] {
    ZC_INIT  = 2'd0,
    ZC_ABOVE = 2'd1,
    ZC_BELOW = 2'd2
  } zc_state_e;

endpackage

// ==== rtl/doppler_settings.sv ====
`timescale 1ns/10ps

module doppler_settings
  import doppler_pkg::*;
#(
  parameter logic [COUNT_W-1:0] PPX_RATE_RESET = 32'd125000000
) (
  input  logic                  ce_clk,
  input  logic                  ce_rst,
  // write strobe
  input  logic                  i_set_stb,
  input  logic [SET_ADDR_W-1:0] i_set_addr,
  input  set_word_u             i_set_data,
  // readback
  input  logic [SET_ADDR_W-1:0] i_rb_addr,
  input  logic [COUNT_W-1:0]    i_count_i,
  input  logic [COUNT_W-1:0]    i_count_q,
  // settings out
  output iq_pair_t              o_threshold,
  output iq_pair_t              o_offset,
  output logic [COUNT_W-1:0]    o_rate,
  output logic                  o_rate_changed,
  output logic [RB_DATA_W-1:0]  o_rb_data
);

  iq_pair_t           threshold_r;
  iq_pair_t           offset_r;
  logic [COUNT_W-1:0] rate_r;
  logic               rate_changed_r;

  // ----------------------------------------------------------
  // register bank
  // ----------------------------------------------------------
  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      threshold_r    <= '0;
      offset_r       <= '0;
      rate_r         <= PPX_RATE_RESET;
      rate_changed_r <= 1'b0;
    end else begin
      rate_changed_r <= 1'b0;
      if (i_set_stb) begin
        case (i_set_addr)
          // per-rail values through the pair view
          SR_THRESHOLD: threshold_r <= i_set_data.pair;
          SR_OFFSET:    offset_r    <= i_set_data.pair;
          // interval length as a plain word
          SR_PPX_RATE: begin
            rate_r         <= i_set_data.word;
            rate_changed_r <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  assign o_threshold    = threshold_r;
  assign o_offset       = offset_r;
  assign o_rate         = rate_r;
  assign o_rate_changed = rate_changed_r;

  // ----------------------------------------------------------
  // readback mux
  // ----------------------------------------------------------
  always_comb begin
    case (i_rb_addr)
      RB_SETTINGS: o_rb_data = {threshold_r, offset_r};
      RB_COUNTS:   o_rb_data = {i_count_i, i_count_q};
      RB_RATE:     o_rb_data = {{(RB_DATA_W-COUNT_W){1'b0}}, rate_r};
      default:     o_rb_data = RB_BAD;
    endcase
  end

endmodule

// ==== rtl/doppler_tracker_top.sv ====
`timescale 1ns/10ps

module doppler_tracker_top
  import doppler_pkg::*;
#(
  parameter logic [COUNT_W-1:0] PPX_RATE_RESET = 32'd125000000
) (
  input  logic                  ce_clk,
  input  logic                  ce_rst,
  // settings bus
  input  logic                  i_set_stb,
  input  logic [SET_ADDR_W-1:0] i_set_addr,
  input  set_word_u             i_set_data,
  // sample strobe
  input  logic                  i_sample_valid,
  input  iq_pair_t              i_sample,
  // readback and result
  input  logic [SET_ADDR_W-1:0] i_rb_addr,
  output logic [COUNT_W-1:0]    o_rate,
  output logic                  o_rate_valid,
  output logic [RB_DATA_W-1:0]  o_rb_data
);

  iq_pair_t           threshold;
  iq_pair_t           offset;
  logic [COUNT_W-1:0] ppx_rate;
  logic               ppx_rate_changed;
  logic               ppx;
  logic               crossing_i;
  logic               crossing_q;
  logic [COUNT_W-1:0] count_i;
  logic [COUNT_W-1:0] count_q;

  doppler_settings #(
    .PPX_RATE_RESET(PPX_RATE_RESET)
  ) doppler_settings_i (
    .ce_clk        (ce_clk),
    .ce_rst        (ce_rst),
    .i_set_stb     (i_set_stb),
    .i_set_addr    (i_set_addr),
    .i_set_data    (i_set_data),
    .i_rb_addr     (i_rb_addr),
    .i_count_i     (count_i),
    .i_count_q     (count_q),
    .o_threshold   (threshold),
    .o_offset      (offset),
    .o_rate        (ppx_rate),
    .o_rate_changed(ppx_rate_changed),
    .o_rb_data     (o_rb_data)
  );

  ppx_timer ppx_timer_i (
    .ce_clk   (ce_clk),
    .ce_rst   (ce_rst),
    .i_rate   (ppx_rate),
    .i_restart(ppx_rate_changed),
    .o_ppx    (ppx)
  );

  // ----------------------------------------------------------
  // one detector per rail
  // ----------------------------------------------------------
  zc_detector zc_detector_i (
    .ce_clk     (ce_clk),
    .ce_rst     (ce_rst),
    .i_valid    (i_sample_valid),
    .i_sample   (i_sample.i),
    .i_threshold(threshold.i),
    .i_offset   (offset.i),
    .o_crossing (crossing_i)
  );

  zc_detector zc_detector_q (
    .ce_clk     (ce_clk),
    .ce_rst     (ce_rst),
    .i_valid    (i_sample_valid),
    .i_sample   (i_sample.q),
    .i_threshold(threshold.q),
    .i_offset   (offset.q),
    .o_crossing (crossing_q)
  );

  crossing_rate_counter crossing_rate_counter_i (
    .ce_clk      (ce_clk),
    .ce_rst      (ce_rst),
    .i_crossing_i(crossing_i),
    .i_crossing_q(crossing_q),
    .i_ppx       (ppx),
    .o_count_i   (count_i),
    .o_count_q   (count_q),
    .o_rate      (o_rate),
    .o_rate_valid(o_rate_valid)
  );

endmodule

// ==== rtl/ppx_timer.sv ====
`timescale 1ns/10ps

module ppx_timer
  import doppler_pkg::*;
(
  input  logic               ce_clk,
  input  logic               ce_rst,
  input  logic [COUNT_W-1:0] i_rate,
  input  logic               i_restart,
  output logic               o_ppx
);

  logic [COUNT_W-1:0] count_r;
  logic [COUNT_W-1:0] rate_eff;
  logic               terminal;

  // too-short intervals run at the minimum
  assign rate_eff = (i_rate < PPX_RATE_MIN) ? PPX_RATE_MIN : i_rate;

  // last cycle of the interval
  // held off while restarting, the count is stale then
  assign terminal = (count_r == rate_eff - 1'b1) && !i_restart;

  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      count_r <= '0;
    end else if (i_restart || terminal) begin
      count_r <= '0;
    end else begin
      count_r <= count_r + 1'b1;
    end
  end

  // one cycle per interval
  assign o_ppx = terminal;

endmodule

// ==== rtl/zc_detector.sv ====
`timescale 1ns/10ps

module zc_detector
  import doppler_pkg::*;
(
  input  logic                       ce_clk,
  input  logic                       ce_rst,
  input  logic                       i_valid,
  input  logic signed [SAMPLE_W-1:0] i_sample,
  input  logic signed [SAMPLE_W-1:0] i_threshold,
  input  logic signed [SAMPLE_W-1:0] i_offset,
  output logic                       o_crossing
);

  // one extra bit so the band edges never wrap
  logic signed [SAMPLE_W:0] sample_x;
  logic signed [SAMPLE_W:0] band_hi;
  logic signed [SAMPLE_W:0] band_lo;
  logic                     is_above;
  logic                     is_below;

  zc_state_e state_r;
  zc_state_e state_nxt;
  logic      crossing_r;

  assign sample_x = {i_sample[SAMPLE_W-1], i_sample};
  assign band_hi  = {i_offset[SAMPLE_W-1], i_offset} + {i_threshold[SAMPLE_W-1], i_threshold};
  assign band_lo  = {i_offset[SAMPLE_W-1], i_offset} - {i_threshold[SAMPLE_W-1], i_threshold};

  assign is_above = (sample_x >= band_hi);
  assign is_below = (sample_x <= band_lo);

  // ----------------------------------------------------------
  // hysteresis FSM
  // ----------------------------------------------------------
  always_comb begin
    state_nxt = state_r;
    if (i_valid) begin
      // upper edge wins if the band is inverted
      if (is_above) begin
        state_nxt = ZC_ABOVE;
      end else if (is_below) begin
        state_nxt = ZC_BELOW;
      end
    end
  end

  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      state_r    <= ZC_INIT;
      crossing_r <= 1'b0;
    end else begin
      state_r <= state_nxt;
      // only below to above counts and leaving init does not
      crossing_r <= (state_r == ZC_BELOW) && (state_nxt == ZC_ABOVE);
    end
  end

  assign o_crossing = crossing_r;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the doppler tracker testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 \
  -f build.f \
  --top-module tb_doppler_tracker \
  -o tb_doppler_tracker_sim

./obj_dir/tb_doppler_tracker_sim > "$LOG" 2>&1
cat "$LOG"

# the log decides the result
if grep -qx "Everything OK" "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation did not pass, see $LOG"
exit 1

// ==== verification/tb_doppler_tracker.sv ====
`timescale 1ns/10ps

module tb_doppler_tracker
  import doppler_pkg::*;
();

  localparam time                CLK_PERIOD = 20;
  localparam logic [COUNT_W-1:0] RATE_RESET = 32'd200;
  localparam logic [COUNT_W-1:0] RATE_NEW   = 32'd150;
  localparam time                N_WINDOWS  = 36;
  localparam time                WATCHDOG_T = N_WINDOWS * time'(RATE_RESET) * CLK_PERIOD * 2;
  localparam int                 WAIT_LIMIT = 2 * int'(RATE_RESET) + 10;

  typedef struct packed {
    logic [COUNT_W-1:0] ci;
    logic [COUNT_W-1:0] cq;
  } window_t;

  logic                  ce_clk;
  logic                  ce_rst;
  logic                  i_set_stb;
  logic [SET_ADDR_W-1:0] i_set_addr;
  set_word_u             i_set_data;
  logic                  i_sample_valid;
  iq_pair_t              i_sample;
  logic [SET_ADDR_W-1:0] i_rb_addr;
  logic [COUNT_W-1:0]    o_rate;
  logic                  o_rate_valid;
  logic [RB_DATA_W-1:0]  o_rb_data;

  integer   seed = 99;
  int       error_count = 0;
  int       windows_checked = 0;
  int       drive_mode = 0;
  int       seg_left = 0;
  int       seg_kind = 0;
  int       swing_base;
  bit       swing_pos = 1'b0;
  time      release_t;
  time      valid_t;
  iq_pair_t thr_set;
  iq_pair_t off_set;

  // model state
  logic [COUNT_W-1:0] m_cyc;
  logic [COUNT_W-1:0] m_rate;
  logic [COUNT_W-1:0] m_eff;
  logic               m_restart;
  logic               m_close;
  iq_pair_t           m_thr;
  iq_pair_t           m_off;
  zc_state_e          st_i;
  zc_state_e          st_q;
  zc_state_e          st_nxt;
  logic               pend_i;
  logic               pend_q;
  logic [COUNT_W-1:0] run_i;
  logic [COUNT_W-1:0] run_q;
  window_t            model_win;
  window_t            exp_win;
  window_t            exp_q[$];
  time                exp_t[$];

  doppler_tracker_top #(
    .PPX_RATE_RESET(RATE_RESET)
  ) doppler_tracker_top_i (
    .ce_clk        (ce_clk),
    .ce_rst        (ce_rst),
    .i_set_stb     (i_set_stb),
    .i_set_addr    (i_set_addr),
    .i_set_data    (i_set_data),
    .i_sample_valid(i_sample_valid),
    .i_sample      (i_sample),
    .i_rb_addr     (i_rb_addr),
    .o_rate        (o_rate),
    .o_rate_valid  (o_rate_valid),
    .o_rb_data     (o_rb_data)
  );

  initial begin
    ce_clk = 1'b0;
    forever #(CLK_PERIOD / 2) ce_clk = ~ce_clk;
  end

  // ------------------------------------------------------------
  // reference functions
  // ------------------------------------------------------------
  function automatic zc_state_e hyst_next(input zc_state_e st, input logic signed [15:0] s,
                                          input logic signed [15:0] thr,
                                          input logic signed [15:0] off);
    int sv;
    int hi;
    int lo;
    sv = int'(s);
    hi = int'(off) + int'(thr);
    lo = int'(off) - int'(thr);
    if (sv >= hi) return ZC_ABOVE;
    if (sv <= lo) return ZC_BELOW;
    return st;
  endfunction

  // floor of the I/Q average
  function automatic logic [COUNT_W-1:0] mean_of(input logic [COUNT_W-1:0] a,
                                                 input logic [COUNT_W-1:0] b);
    longint total;
    total = longint'(a) + longint'(b);
    return COUNT_W'(total / 2);
  endfunction

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------
  task automatic check_rate(input logic [COUNT_W-1:0] got, input logic [COUNT_W-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s got %0d expected %0d", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_rb(input logic [RB_DATA_W-1:0] got, input logic [RB_DATA_W-1:0] exp,
                          input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_pair(input iq_pair_t got, input iq_pair_t exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s got i=%0d q=%0d expected i=%0d q=%0d",
               $time, what, got.i, got.q, exp.i, exp.q);
      error_count++;
    end
  endtask

  // ------------------------------------------------------------
  // bus helpers
  // ------------------------------------------------------------
  task automatic write_setting(input logic [SET_ADDR_W-1:0] addr, input set_word_u data);
    @(negedge ce_clk);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    @(negedge ce_clk);
    i_set_stb = 1'b0;
  endtask

  task automatic read_rb(input logic [SET_ADDR_W-1:0] addr, output logic [RB_DATA_W-1:0] data);
    @(negedge ce_clk);
    i_rb_addr = addr;
    #1;
    data = o_rb_data;
  endtask

  task automatic wait_valid(input int limit);
    int n;
    n = 0;
    while (n < limit) begin
      @(negedge ce_clk);
      n++;
      if (o_rate_valid) break;
    end
    if (!o_rate_valid) begin
      $display("no o_rate_valid seen within %0d cycles at %0t", limit, $time);
      error_count++;
    end
    valid_t = $time;
  endtask

  // ------------------------------------------------------------
  // sample driver with random data, swings and in-band noise
  // ------------------------------------------------------------
  initial begin
    i_sample_valid = 1'b0;
    i_sample       = '0;
    forever begin
      @(negedge ce_clk);
      if (drive_mode == 0) begin
        i_sample_valid = 1'b0;
      end else begin
        if (seg_left == 0) begin
          seg_kind  = int'($unsigned($random(seed)) % 3);
          seg_left  = 8 + int'($unsigned($random(seed)) % 40);
          swing_pos = !swing_pos;
        end
        seg_left = seg_left - 1;
        i_sample_valid = (drive_mode == 2) || (($random(seed) & 3) != 0);
        swing_base = swing_pos ? 9000 : -9000;
        case ((drive_mode == 2) ? 2 : seg_kind)
          0: i_sample = iq_pair_t'($random(seed));
          1: begin
            i_sample.i = 16'(swing_base + $random(seed) % 500);
            i_sample.q = 16'(-swing_base + $random(seed) % 500);
          end
          default: begin
            // stays strictly inside both bands
            i_sample.i = 16'(int'(off_set.i) + $random(seed) % 400);
            i_sample.q = 16'(int'(off_set.q) + $random(seed) % 250);
          end
        endcase
      end
    end
  end

  // ------------------------------------------------------------
  // reference model, stepped on every rising edge
  // ------------------------------------------------------------
  always @(posedge ce_clk) begin
    if (ce_rst) begin
      m_cyc     = '0;
      m_rate    = RATE_RESET;
      m_restart = 1'b0;
      m_thr     = '0;
      m_off     = '0;
      st_i      = ZC_INIT;
      st_q      = ZC_INIT;
      pend_i    = 1'b0;
      pend_q    = 1'b0;
      run_i     = '0;
      run_q     = '0;
      exp_q.delete();
      exp_t.delete();
    end else begin
      // window edge from the interval counter
      m_eff   = (m_rate < PPX_RATE_MIN) ? PPX_RATE_MIN : m_rate;
      m_close = !m_restart && (m_cyc == m_eff - 32'd1);
      m_cyc   = (m_restart || m_close) ? '0 : m_cyc + 32'd1;
      m_restart = 1'b0;
      // crossings from the previous edge land here
      if (m_close) begin
        model_win.ci = run_i;
        model_win.cq = run_q;
        exp_q.push_back(model_win);
        exp_t.push_back($time);
        run_i = COUNT_W'(pend_i);
        run_q = COUNT_W'(pend_q);
      end else begin
        run_i = run_i + COUNT_W'(pend_i);
        run_q = run_q + COUNT_W'(pend_q);
      end
      pend_i = 1'b0;
      pend_q = 1'b0;
      if (i_sample_valid) begin
        st_nxt = hyst_next(st_i, i_sample.i, m_thr.i, m_off.i);
        pend_i = (st_i == ZC_BELOW) && (st_nxt == ZC_ABOVE);
        st_i   = st_nxt;
        st_nxt = hyst_next(st_q, i_sample.q, m_thr.q, m_off.q);
        pend_q = (st_q == ZC_BELOW) && (st_nxt == ZC_ABOVE);
        st_q   = st_nxt;
      end
      // writes on this edge apply from the next one
      if (i_set_stb) begin
        case (i_set_addr)
          SR_THRESHOLD: m_thr = i_set_data.pair;
          SR_OFFSET:    m_off = i_set_data.pair;
          SR_PPX_RATE: begin
            m_rate    = i_set_data.word;
            m_restart = 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  // result compare
  always @(posedge ce_clk) begin
    if (!ce_rst) begin
      if (o_rate_valid) begin
        if (exp_q.size() == 0) begin
          $display("o_rate_valid pulsed at %0t with no window closed in the model", $time);
          error_count++;
        end else begin
          exp_win = exp_q.pop_front();
          void'(exp_t.pop_front());
          check_rate(o_rate, mean_of(exp_win.ci, exp_win.cq), "window mean");
          if (i_rb_addr == RB_COUNTS) begin
            check_rb(o_rb_data, {exp_win.ci, exp_win.cq}, "counts readback");
          end
          windows_checked++;
        end
      end else if (exp_t.size() > 0 && exp_t[0] + CLK_PERIOD <= $time) begin
        $display("o_rate_valid missing for the window closed at %0t", exp_t[0]);
        error_count++;
        void'(exp_q.pop_front());
        void'(exp_t.pop_front());
      end
    end
  end

  initial begin
    #(WATCHDOG_T);
    $display("watchdog expired at %0t before the test sequence finished", $time);
    $display("Something failed");
    $finish;
  end

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    logic [RB_DATA_W-1:0] rb;
    set_word_u            wr;
    time                  prev_t;
    $timeformat(-9, 0, " ns", 0);
    ce_rst     = 1'b1;
    i_set_stb  = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_rb_addr  = RB_SETTINGS;
    thr_set    = '{i: 16'sd500, q: 16'sd300};
    off_set    = '{i: 16'sd100, q: -16'sd200};
    repeat (10) @(posedge ce_clk);
    @(negedge ce_clk);
    ce_rst    = 1'b0;
    release_t = $time;

    // reset values, then the first window at the reset rate
    read_rb(RB_SETTINGS, rb);
    check_rb(rb, '0, "settings after reset");
    read_rb(RB_RATE, rb);
    check_rb(rb, {32'd0, RATE_RESET}, "rate after reset");
    i_rb_addr = RB_COUNTS;
    wait_valid(WAIT_LIMIT);
    check_rate(COUNT_W'((valid_t - release_t) / CLK_PERIOD), RATE_RESET,
               "cycles to first result");

    // pair view writes and random traffic
    wr.pair = thr_set;
    write_setting(SR_THRESHOLD, wr);
    wr.pair = off_set;
    write_setting(SR_OFFSET, wr);
    read_rb(RB_SETTINGS, rb);
    check_pair(iq_pair_t'(rb[63:32]), thr_set, "threshold readback");
    check_pair(iq_pair_t'(rb[31:0]), off_set, "offset readback");
    i_rb_addr  = RB_COUNTS;
    drive_mode = 1;
    repeat (24) wait_valid(WAIT_LIMIT);

    // in-band samples only so the second window stays clean
    drive_mode = 2;
    repeat (2) wait_valid(WAIT_LIMIT);
    check_rate(o_rate, '0, "in-band window mean");

    // word view rate change
    drive_mode = 1;
    wr.word = RATE_NEW;
    write_setting(SR_PPX_RATE, wr);
    read_rb(RB_RATE, rb);
    check_rb(rb, {32'd0, RATE_NEW}, "rate readback");
    i_rb_addr = RB_COUNTS;
    wait_valid(WAIT_LIMIT);
    repeat (4) begin
      prev_t = valid_t;
      wait_valid(WAIT_LIMIT);
      check_rate(COUNT_W'((valid_t - prev_t) / CLK_PERIOD), RATE_NEW, "result spacing");
    end

    read_rb(8'h55, rb);
    check_rb(rb, RB_BAD, "unused address");
    i_rb_addr  = RB_COUNTS;
    drive_mode = 0;
    repeat (3) @(negedge ce_clk);

    $display("summary: %0d windows compared, %0d errors", windows_checked, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
